// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		FILL,
		WRITE_MEM,
		RESPOND
	} ctrl_state_e;

	typedef enum logic [1:0] {
		REGION_MEM,
		REGION_GPIO,
		REGION_NONE
	} region_e;

	// Address map
	localparam addr_t MEM_BASE  = 32'h0000_0000;
	localparam addr_t GPIO_BASE = 32'h0001_0000;
	localparam addr_t GPIO_SPAN = 32'd8;

	// GPIO register offsets
	localparam int GPIO_OFF_W = 3;
	localparam logic [GPIO_OFF_W-1:0] GPIO_LED_OFF = 3'd0;
	localparam logic [GPIO_OFF_W-1:0] GPIO_SW_OFF  = 3'd4;

	localparam int DEF_CACHE_ADDR_W = 6;
	localparam int DEF_MEM_ADDR_W   = 12;   // 16 KiB of words
	localparam int DEF_MEM_LATENCY  = 4;

endpackage

`default_nettype wire

// File: tag_table.sv
`timescale 1ns/1ns
`default_nettype none

module tag_table #(
	parameter int CACHE_ADDR_W = soc_pkg::DEF_CACHE_ADDR_W,
	parameter int MEM_ADDR_W   = soc_pkg::DEF_MEM_ADDR_W
) (
	input  wire                                clk_i,
	input  wire                                reset_i,
	input  wire  [CACHE_ADDR_W-1:0]            index_i,
	input  wire  [MEM_ADDR_W-CACHE_ADDR_W-1:0] tag_i,
	input  wire                                we_i,
	output logic                               hit_o
);
	localparam int TAG_W = MEM_ADDR_W - CACHE_ADDR_W;
	localparam int DEPTH = 2 ** CACHE_ADDR_W;

	logic [DEPTH-1:0] valid_q;
	logic [TAG_W-1:0] tags_q [DEPTH];

	always_ff @(posedge clk_i) begin
		if (reset_i)
			valid_q <= '0;
		else if (we_i)
			valid_q[index_i] <= 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (we_i)
			tags_q[index_i] <= tag_i;
	end

	assign hit_o = valid_q[index_i] && (tags_q[index_i] == tag_i);  // Combinational compare

endmodule

`default_nettype wire

// File: data_array.sv
`timescale 1ns/1ns
`default_nettype none

module data_array #(
	parameter int CACHE_ADDR_W = soc_pkg::DEF_CACHE_ADDR_W
) (
	input  wire                     clk_i,
	input  wire  [CACHE_ADDR_W-1:0] index_i,
	input  wire                     we_i,
	input  soc_pkg::strb_t          strb_i,
	input  soc_pkg::data_t          wdata_i,
	output soc_pkg::data_t          rdata_o
);
	localparam int DEPTH = 2 ** CACHE_ADDR_W;

	logic [31:0] words_q [DEPTH];

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (strb_i[lane])
					words_q[index_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
			end
		end
	end

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clk_i) begin
		rdata_o <= words_q[index_i];
	end

endmodule

`default_nettype wire

// File: main_mem.sv
`timescale 1ns/1ns
`default_nettype none

module main_mem #(
	parameter int MEM_ADDR_W  = soc_pkg::DEF_MEM_ADDR_W,
	parameter int MEM_LATENCY = soc_pkg::DEF_MEM_LATENCY
) (
	input  wire                   clk_i,
	input  wire                   reset_i,
	input  wire                   req_i,
	input  wire                   we_i,
	input  wire  [MEM_ADDR_W-1:0] addr_i,
	input  soc_pkg::data_t        wdata_i,
	input  soc_pkg::strb_t        strb_i,
	output logic                  ack_o,
	output soc_pkg::data_t        rdata_o
);
	localparam int DEPTH = 2 ** MEM_ADDR_W;
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [31:0]           words_q [DEPTH];
	logic [MEM_ADDR_W-1:0] addr_q;
	logic [CNT_W-1:0]      cnt_q;
	logic                  busy_q;

	// Write lands at request time
	always_ff @(posedge clk_i) begin
		if (req_i && we_i) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (strb_i[lane])
					words_q[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			ack_o  <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			if (req_i) begin
				addr_q <= addr_i;
				cnt_q  <= CNT_W'(MEM_LATENCY - 1);
				if (MEM_LATENCY == 1) begin
					ack_o   <= 1'b1;
					rdata_o <= words_q[addr_i];
				end else begin
					busy_q <= 1'b1;
				end
			end else if (busy_q) begin
				if (cnt_q == CNT_W'(1)) begin
					busy_q  <= 1'b0;
					ack_o   <= 1'b1;
					rdata_o <= words_q[addr_q];  // Sampled with the ack
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: gpio_regs.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
	input  wire                            clk_i,
	input  wire                            reset_i,
	input  wire                            we_i,
	input  wire  [soc_pkg::GPIO_OFF_W-1:0] offset_i,
	input  soc_pkg::data_t                 wdata_i,
	input  soc_pkg::strb_t                 strb_i,
	output soc_pkg::data_t                 rdata_o,
	input  wire  [3:0]                     sw_i,
	output logic [7:0]                     led_o
);
	import soc_pkg::*;

	logic [3:0] sw_meta_q;
	logic [3:0] sw_sync_q;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			led_o <= '0;
		else if (we_i && offset_i == GPIO_LED_OFF && strb_i[0])
			led_o <= wdata_i[7:0];  // Lane 0 only
	end

	// Two-stage synchronizer for the switches
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			sw_meta_q <= '0;
			sw_sync_q <= '0;
		end else begin
			sw_meta_q <= sw_i;
			sw_sync_q <= sw_meta_q;
		end
	end

	always_comb begin
		case (offset_i)
			GPIO_LED_OFF: rdata_o = {24'd0, led_o};
			GPIO_SW_OFF:  rdata_o = {28'd0, sw_sync_q};
			default:      rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl #(
	parameter int CACHE_ADDR_W = soc_pkg::DEF_CACHE_ADDR_W,
	parameter int MEM_ADDR_W   = soc_pkg::DEF_MEM_ADDR_W
) (
	input  wire                                clk_i,
	input  wire                                reset_i,
	input  wire                                req_i,
	input  wire                                we_i,
	input  soc_pkg::addr_t                     addr_i,
	input  soc_pkg::data_t                     wdata_i,
	input  soc_pkg::strb_t                     strb_i,
	output logic                               done_o,
	output logic                               err_o,
	output soc_pkg::data_t                     rdata_o,
	input  wire                                tag_hit_i,
	output logic                               tag_we_o,
	output logic [CACHE_ADDR_W-1:0]            index_o,
	output logic [MEM_ADDR_W-CACHE_ADDR_W-1:0] tag_o,
	output logic                               arr_we_o,
	input  soc_pkg::data_t                     arr_rdata_i,
	output soc_pkg::data_t                     arr_wdata_o,
	output soc_pkg::strb_t                     arr_strb_o,
	output logic                               mem_req_o,
	output logic                               mem_we_o,
	output logic [MEM_ADDR_W-1:0]              mem_addr_o,
	output soc_pkg::data_t                     mem_wdata_o,
	output soc_pkg::strb_t                     mem_strb_o,
	input  wire                                mem_ack_i,
	input  soc_pkg::data_t                     mem_rdata_i,
	output logic                               gpio_we_o,
	output logic [soc_pkg::GPIO_OFF_W-1:0]     gpio_offset_o,
	input  soc_pkg::data_t                     gpio_rdata_i
);
	import soc_pkg::*;

	localparam addr_t MEM_SPAN = addr_t'(4) << MEM_ADDR_W;

	ctrl_state_e state_q, state_d;
	region_e     region_d, region_q;
	addr_t       addr_q;
	data_t       wdata_q;
	strb_t       strb_q;
	logic        we_q;
	logic        mem_req_q;
	logic        miss_q;      // Read went through a line fill
	logic        accept;
	logic [MEM_ADDR_W-1:0] word_addr;

	function automatic region_e decode(addr_t a);
		if ((a - MEM_BASE) < MEM_SPAN)
			return REGION_MEM;
		if ((a - GPIO_BASE) < GPIO_SPAN)
			return REGION_GPIO;
		return REGION_NONE;
	endfunction

	assign region_d = decode(addr_i);
	assign accept   = (state_q == IDLE) && req_i;

	always_ff @(posedge clk_i) begin
		if (accept) begin
			addr_q   <= addr_i;
			we_q     <= we_i;
			wdata_q  <= wdata_i;
			strb_q   <= strb_i;
			region_q <= region_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (req_i) begin
					if (region_d == REGION_MEM)
						state_d = we_i ? WRITE_MEM : LOOKUP;
					else
						state_d = RESPOND;  // GPIO and unmapped answer at once
				end
			end
			LOOKUP:    state_d = tag_hit_i ? RESPOND : FILL;
			FILL:      state_d = mem_ack_i ? RESPOND : FILL;
			WRITE_MEM: state_d = mem_ack_i ? RESPOND : WRITE_MEM;
			RESPOND:   state_d = IDLE;
			default:   state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q   <= IDLE;
			mem_req_q <= 1'b0;
			miss_q    <= 1'b0;
		end else begin
			state_q <= state_d;
			// Write-through goes out right away, fill after the miss
			mem_req_q <= (accept && region_d == REGION_MEM && we_i) ||
				(state_q == LOOKUP && !tag_hit_i);
			if (accept)
				miss_q <= 1'b0;
			else if (state_q == LOOKUP && !tag_hit_i)
				miss_q <= 1'b1;
		end
	end

	assign word_addr = addr_q[MEM_ADDR_W+1:2];
	assign index_o   = word_addr[CACHE_ADDR_W-1:0];
	assign tag_o     = word_addr[MEM_ADDR_W-1:CACHE_ADDR_W];

	assign tag_we_o    = (state_q == FILL) && mem_ack_i;
	assign arr_we_o    = tag_we_o || ((state_q == WRITE_MEM) && mem_ack_i && tag_hit_i);
	assign arr_wdata_o = (state_q == FILL) ? mem_rdata_i : wdata_q;
	assign arr_strb_o  = (state_q == FILL) ? '1 : strb_q;

	assign mem_req_o   = mem_req_q;
	assign mem_we_o    = we_q;
	assign mem_addr_o  = word_addr;
	assign mem_wdata_o = wdata_q;
	assign mem_strb_o  = strb_q;

	assign gpio_we_o     = (state_q == RESPOND) && (region_q == REGION_GPIO) && we_q;
	assign gpio_offset_o = addr_q[GPIO_OFF_W-1:0];

	assign done_o = (state_q == RESPOND);
	assign err_o  = done_o && (region_q == REGION_NONE);

	always_comb begin
		rdata_o = '0;
		if (!we_q) begin
			case (region_q)
				REGION_MEM:  rdata_o = miss_q ? mem_rdata_i : arr_rdata_i;
				REGION_GPIO: rdata_o = gpio_rdata_i;
				default:     rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: soc_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_mem_top #(
	parameter int CACHE_ADDR_W = soc_pkg::DEF_CACHE_ADDR_W,
	parameter int MEM_ADDR_W   = soc_pkg::DEF_MEM_ADDR_W,
	parameter int MEM_LATENCY  = soc_pkg::DEF_MEM_LATENCY
) (
	input  wire            clk_i,
	input  wire            reset_i,
	input  wire            req_i,
	input  wire            we_i,
	input  soc_pkg::addr_t addr_i,
	input  soc_pkg::data_t wdata_i,
	input  soc_pkg::strb_t strb_i,
	output logic           done_o,
	output logic           err_o,
	output soc_pkg::data_t rdata_o,
	input  wire  [3:0]     sw_i,
	output logic [7:0]     led_o
);
	import soc_pkg::*;

	localparam int TAG_W = MEM_ADDR_W - CACHE_ADDR_W;

	// Cache side
	logic                    tag_hit;
	logic                    tag_we;
	logic [CACHE_ADDR_W-1:0] index;
	logic [TAG_W-1:0]        tag;
	logic                    arr_we;
	data_t                   arr_rdata;
	data_t                   arr_wdata;
	strb_t                   arr_strb;

	// Backing memory
	logic                  mem_req;
	logic                  mem_we;
	logic [MEM_ADDR_W-1:0] mem_addr;
	data_t                 mem_wdata;
	strb_t                 mem_strb;
	logic                  mem_ack;
	data_t                 mem_rdata;

	logic                  gpio_we;
	logic [GPIO_OFF_W-1:0] gpio_offset;
	data_t                 gpio_rdata;

	bus_ctrl #(
		.CACHE_ADDR_W(CACHE_ADDR_W),
		.MEM_ADDR_W(MEM_ADDR_W)
	) bus_ctrl_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.strb_i(strb_i),
		.done_o(done_o),
		.err_o(err_o),
		.rdata_o(rdata_o),
		.tag_hit_i(tag_hit),
		.tag_we_o(tag_we),
		.index_o(index),
		.tag_o(tag),
		.arr_we_o(arr_we),
		.arr_rdata_i(arr_rdata),
		.arr_wdata_o(arr_wdata),
		.arr_strb_o(arr_strb),
		.mem_req_o(mem_req),
		.mem_we_o(mem_we),
		.mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata),
		.mem_strb_o(mem_strb),
		.mem_ack_i(mem_ack),
		.mem_rdata_i(mem_rdata),
		.gpio_we_o(gpio_we),
		.gpio_offset_o(gpio_offset),
		.gpio_rdata_i(gpio_rdata)
	);

	tag_table #(
		.CACHE_ADDR_W(CACHE_ADDR_W),
		.MEM_ADDR_W(MEM_ADDR_W)
	) tag_table_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.index_i(index),
		.tag_i(tag),
		.we_i(tag_we),
		.hit_o(tag_hit)
	);

	data_array #(
		.CACHE_ADDR_W(CACHE_ADDR_W)
	) data_array_i (
		.clk_i(clk_i),
		.index_i(index),
		.we_i(arr_we),
		.strb_i(arr_strb),
		.wdata_i(arr_wdata),
		.rdata_o(arr_rdata)
	);

	main_mem #(
		.MEM_ADDR_W(MEM_ADDR_W),
		.MEM_LATENCY(MEM_LATENCY)
	) main_mem_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(mem_req),
		.we_i(mem_we),
		.addr_i(mem_addr),
		.wdata_i(mem_wdata),
		.strb_i(mem_strb),
		.ack_o(mem_ack),
		.rdata_o(mem_rdata)
	);

	gpio_regs gpio_regs_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.we_i(gpio_we),
		.offset_i(gpio_offset),
		.wdata_i(mem_wdata),    // Latched request data
		.strb_i(mem_strb),
		.rdata_o(gpio_rdata),
		.sw_i(sw_i),
		.led_o(led_o)
	);

endmodule

`default_nettype wire

// File: soc_mem_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module soc_mem_asserts (
	input wire clk_i,
	input wire reset_i,
	input wire done_i,
	input wire err_i,
	input wire mem_req_i,
	input wire mem_ack_i
);
	logic mem_busy_q;  // Access to main_mem in flight

	always_ff @(posedge clk_i) begin
		if (reset_i)
			mem_busy_q <= 1'b0;
		else if (mem_req_i)
			mem_busy_q <= 1'b1;
		else if (mem_ack_i)
			mem_busy_q <= 1'b0;
	end

	done_single: assert property (@(posedge clk_i) disable iff (reset_i)
		done_i |=> !done_i)
		else $error("done_o high for two cycles in a row");

	mem_req_idle: assert property (@(posedge clk_i) disable iff (reset_i)
		mem_req_i |-> !mem_busy_q)
		else $error("mem_req_o pulsed with a main_mem access outstanding");

	err_with_done: assert property (@(posedge clk_i) disable iff (reset_i)
		err_i |-> done_i)
		else $error("err_o high without done_o");

endmodule

bind bus_ctrl soc_mem_asserts soc_mem_asserts_i (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.done_i(done_o),
	.err_i(err_o),
	.mem_req_i(mem_req_o),
	.mem_ack_i(mem_ack_i)
);

`default_nettype wire

// File: tb_soc_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_mem;
	import soc_pkg::*;

	localparam int CACHE_ADDR_W = DEF_CACHE_ADDR_W;
	localparam int MEM_ADDR_W   = DEF_MEM_ADDR_W;
	localparam int MEM_LATENCY  = DEF_MEM_LATENCY;
	localparam int LINES        = 2 ** CACHE_ADDR_W;
	localparam int RESET_CYCLES = 8;
	localparam int ACCESS_LIMIT = MEM_LATENCY + 10;
	localparam int LAT_ANY      = -1;

	typedef struct packed {
		logic       we;
		addr_t      addr;
		data_t      data;
		strb_t      strb;
		logic       chk_rdata;
		data_t      rdata;
		logic       err;
		int         lat;
		logic [7:0] led;    // LED value once the access has landed
	} entry_t;

	logic       clk_i;
	logic       reset_i;
	logic       req_i;
	logic       we_i;
	addr_t      addr_i;
	data_t      wdata_i;
	strb_t      strb_i;
	logic       done_o;
	logic       err_o;
	data_t      rdata_o;
	logic [3:0] sw_i;
	logic [7:0] led_o;

	entry_t     table_q[$];
	data_t      mem_model [2**MEM_ADDR_W];
	logic       line_valid [LINES];
	int         line_tag [LINES];
	logic [7:0] led_model;
	logic [3:0] sw_value;
	int         errors;
	int         checks;
	bit         table_built;

	soc_mem_top #(
		.CACHE_ADDR_W(CACHE_ADDR_W),
		.MEM_ADDR_W(MEM_ADDR_W),
		.MEM_LATENCY(MEM_LATENCY)
	) soc_mem_top_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.strb_i(strb_i),
		.done_o(done_o),
		.err_o(err_o),
		.rdata_o(rdata_o),
		.sw_i(sw_i),
		.led_o(led_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	function automatic data_t merge_lanes(data_t old_word, data_t new_word, strb_t strb);
		data_t result;
		result = old_word;
		for (int lane = 0; lane < 4; lane++) begin
			if (strb[lane])
				result[lane*8 +: 8] = new_word[lane*8 +: 8];
		end
		return result;
	endfunction

	task automatic check_value(string name, data_t got, data_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	function automatic entry_t new_entry(logic we, addr_t addr, data_t data, strb_t strb);
		entry_t e;
		e = '0;
		e.we   = we;
		e.addr = addr;
		e.data = data;
		e.strb = strb;
		e.lat  = 1;
		return e;
	endfunction

	// Write-through, no allocation on a miss
	task automatic mem_write_entry(addr_t addr, data_t data, strb_t strb);
		entry_t e;
		int     word;
		word = int'(addr[MEM_ADDR_W+1:2]);
		mem_model[word] = merge_lanes(mem_model[word], data, strb);
		e = new_entry(1'b1, addr, data, strb);
		e.lat = MEM_LATENCY + 2;
		e.led = led_model;
		table_q.push_back(e);
	endtask

	task automatic mem_read_entry(addr_t addr, bit lat_any);
		entry_t e;
		int     word;
		int     idx;
		int     tg;
		word = int'(addr[MEM_ADDR_W+1:2]);
		idx  = word % LINES;
		tg   = word / LINES;
		e = new_entry(1'b0, addr, '0, '0);
		if (line_valid[idx] && line_tag[idx] == tg) begin
			e.lat = 2;
		end else begin
			e.lat = MEM_LATENCY + 3;   // Miss fills the line
			line_valid[idx] = 1'b1;
			line_tag[idx]   = tg;
		end
		if (lat_any)
			e.lat = LAT_ANY;
		e.chk_rdata = 1'b1;
		e.rdata     = mem_model[word];
		e.led       = led_model;
		table_q.push_back(e);
	endtask

	task automatic gpio_write_entry(int offset, data_t data, strb_t strb);
		entry_t e;
		if (offset == 0 && strb[0])
			led_model = data[7:0];
		e = new_entry(1'b1, GPIO_BASE + addr_t'(offset), data, strb);
		e.led = led_model;
		table_q.push_back(e);
	endtask

	task automatic gpio_read_entry(int offset);
		entry_t e;
		e = new_entry(1'b0, GPIO_BASE + addr_t'(offset), '0, '0);
		e.chk_rdata = 1'b1;
		if (offset == 0)
			e.rdata = {24'd0, led_model};
		else if (offset == 4)
			e.rdata = {28'd0, sw_value};
		e.led = led_model;
		table_q.push_back(e);
	endtask

	task automatic unmapped_entry(logic we, addr_t addr, data_t data);
		entry_t e;
		e = new_entry(we, addr, data, 4'hf);
		e.err = 1'b1;
		e.led = led_model;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		addr_t a_addr;
		addr_t b_addr;
		addr_t c_addr;
		a_addr = 32'h0000_0040;
		b_addr = 32'h0000_0124;
		c_addr = 32'h0000_2124;    // Same index as b_addr, other tag
		for (int i = 0; i < LINES; i++)
			line_valid[i] = 1'b0;
		led_model = '0;
		gpio_read_entry(0);
		mem_write_entry(a_addr, $urandom, 4'hf);
		mem_read_entry(a_addr, 1'b1);
		mem_read_entry(a_addr, 1'b0);
		mem_write_entry(a_addr, $urandom, 4'b0101);
		mem_read_entry(a_addr, 1'b0);
		mem_write_entry(a_addr, $urandom, 4'b1000);
		mem_read_entry(a_addr, 1'b0);
		mem_write_entry(b_addr, $urandom, 4'hf);
		mem_write_entry(c_addr, $urandom, 4'hf);
		for (int i = 0; i < 2; i++) begin
			mem_read_entry(b_addr, 1'b0);
			mem_read_entry(c_addr, 1'b0);
		end
		gpio_write_entry(0, $urandom, 4'hf);
		gpio_read_entry(0);
		gpio_write_entry(0, $urandom, 4'b1110);  // Lane 0 off, LEDs keep value
		gpio_write_entry(4, $urandom, 4'hf);
		gpio_read_entry(4);
		unmapped_entry(1'b1, 32'h0002_0040, $urandom);
		unmapped_entry(1'b1, GPIO_BASE + 32'd8, $urandom);
		unmapped_entry(1'b0, 32'h8000_0000, '0);
		mem_read_entry(a_addr, 1'b0);
		gpio_read_entry(0);
	endtask

	task automatic run_entry(entry_t e);
		int   cycles;
		logic seen;
		@(posedge clk_i);
		req_i   <= 1'b1;
		we_i    <= e.we;
		addr_i  <= e.addr;
		wdata_i <= e.data;
		strb_i  <= e.strb;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < ACCESS_LIMIT) begin
			@(posedge clk_i);
			req_i   <= 1'b0;
			// Bus fields only hold with req_i
			we_i    <= ~e.we;
			addr_i  <= ~e.addr;
			wdata_i <= ~e.data;
			strb_i  <= ~e.strb;
			cycles++;
			@(negedge clk_i);
			seen = done_o;
		end
		if (!seen) begin
			errors++;
			$display("No done strobe for the access to address %h within %0d cycles",
				e.addr, ACCESS_LIMIT);
			return;
		end
		check_value("err_o", 32'(err_o), 32'(e.err));
		if (e.chk_rdata)
			check_value("rdata_o", rdata_o, e.rdata);
		if (e.lat != LAT_ANY)
			check_value("latency", 32'(cycles), 32'(e.lat));
		@(negedge clk_i);
		check_value("led_o", 32'(led_o), 32'(e.led));
	endtask

	initial begin
		wait (table_built);
		repeat (table_q.size() * (MEM_LATENCY + 10) + RESET_CYCLES) @(posedge clk_i);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h8e994a18));
		errors   = 0;
		checks   = 0;
		sw_value = 4'($urandom) | 4'h1;   // Nonzero so the switch read means something
		reset_i  = 1'b1;
		req_i    = 1'b0;
		we_i     = 1'b0;
		addr_i   = '0;
		wdata_i  = '0;
		strb_i   = '0;
		sw_i     = sw_value;
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_i);
		reset_i <= 1'b0;
		@(negedge clk_i);
		check_value("done_o", 32'(done_o), 32'h0);
		check_value("err_o", 32'(err_o), 32'h0);
		check_value("led_o", 32'(led_o), 32'h0);
		foreach (table_q[i])
			run_entry(table_q[i]);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
soc_pkg.sv
tag_table.sv
data_array.sv
main_mem.sv
gpio_regs.sv
bus_ctrl.sv
soc_mem_top.sv
soc_mem_asserts.sv
tb_soc_mem.sv

// File: Bender.yml
package:
  name: soc_mem

sources:
  - soc_pkg.sv
  - tag_table.sv
  - data_array.sv
  - main_mem.sv
  - gpio_regs.sv
  - bus_ctrl.sv
  - soc_mem_top.sv
  - target: simulation
    files:
      - soc_mem_asserts.sv
      - tb_soc_mem.sv
